// File: common/intr_pkg.sv
package intr_pkg;

	// slice and bus sizes
	localparam int num_irq = 32;
	localparam int num_mask = 10;
	localparam int word_w = 16;
	localparam int chan_count = 16; // channel interrupts from the system bus

	// request slice index of each source, lower index wins
	localparam int irq_nmi = 0; // power out
	localparam int irq_parity = 1; // memory parity error
	localparam int irq_nomem = 2;
	localparam int irq_cpu_hi = 3; // other CPU, high priority
	localparam int irq_ifpwr = 4; // interface power out
	localparam int irq_timer = 5;
	localparam int irq_illegal = 6; // illegal instruction
	localparam int irq_fi0 = 7; // fixed point div overflow
	localparam int irq_fi1 = 8; // float underflow
	localparam int irq_fi2 = 9; // float overflow
	localparam int irq_fi3 = 10; // div by zero, float error
	// index 11 has no source
	localparam int irq_chan0 = 12; // first of the channel slices
	localparam int irq_oprq = 28; // operator request
	localparam int irq_cpu_lo = 29; // other CPU, low priority
	localparam int irq_soft_hi = 30;
	localparam int irq_soft_lo = 31;

	// last slice under each mask bit
	// slice 0 sits in front of group 0 and ignores the mask
	localparam int mask_group_last [0:num_mask-1] = '{
		1, 2, 3, 4, // one slice per bit
		11,
		13,
		15,
		21,
		27,
		31
	};

endpackage

// File: logic/mask_reg.sv
module mask_reg(
	input logic __clk,
	input logic rst_n,
	input logic clr, // master clear
	input logic load, // mask load from the internal bus
	input logic enter, // cycle after interrupt entry
	input logic [0:intr_pkg::num_mask-1] w,
	input logic [0:intr_pkg::num_mask-1] zi, // chain grant at each group end
	output logic [0:intr_pkg::num_mask-1] rs
);

	// mask update, one edge after the enable
	always_ff @(posedge __clk) begin
		if (!rst_n || clr) begin
			rs <= '0;
		end else if (load) begin
			rs <= w; // straight copy of w[0:9]
		end else if (enter) begin
			// chain is broken at the serviced slice
			// so its group and every later group drop out
			rs <= rs & zi;
		end
	end

endmodule

// File: logic/req_slice.sv
module req_slice(
	input logic __clk,
	input logic rst_n,
	input logic imask, // mask gate for this slice
	input logic irq_in, // source, already a clock-domain level
	input logic w_set, // software value from w
	input logic rz_clk, // software load enable
	input logic rz_rst, // group clear
	input logic rp_clk, // interrupt entry
	input logic prio_in, // chain from the higher priority neighbour
	output logic rz,
	output logic sz,
	output logic rp,
	output logic prio_out
);

	logic rp_new; // service bit loaded on the last edge

	assign sz = rz & imask; // pending and unmasked
	assign prio_out = prio_in & ~sz; // chain stops at the first pending slice

	// request bit
	always_ff @(posedge __clk) begin
		if (!rst_n || rz_rst) begin
			rz <= 1'b0;
		end else if (rp && rp_new) begin
			rz <= 1'b0; // taken into service
		end else if (rz_clk) begin
			rz <= w_set | irq_in; // software write replaces the bit
		end else if (irq_in) begin
			rz <= 1'b1;
		end
	end

	// service bit
	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			rp <= 1'b0;
			rp_new <= 1'b0;
		end else begin
			rp_new <= rp_clk;
			if (rp_clk)
				rp <= prio_in & sz; // only the chain winner catches a one
		end
	end

endmodule

// File: logic/chan_ack.sv
module chan_ack #(
	parameter int dok_dly_ticks = 3,
	parameter int dok_ticks = 4
) (
	input logic __clk,
	input logic rst_n,
	input logic rin, // bus request, held by the requester
	input logic [0:intr_pkg::word_w-1] rdt,
	input logic zgpn_, // high when channel interrupts are accepted
	output logic dok,
	output logic cpu_hi,
	output logic cpu_lo,
	output logic [0:intr_pkg::chan_count-1] chan_req
);

	import intr_pkg::*;

	localparam int dly_w = $clog2(dok_dly_ticks + 1);
	localparam int win_w = $clog2(dok_ticks + 1);

	logic [dly_w-1:0] dly_cnt; // settle time of rin
	logic [win_w-1:0] win_cnt; // one-shot, counts down
	logic fire; // delay elapses on this edge
	logic win; // one-shot window open
	logic is_chan; // case A, channel interrupt
	logic is_cpu; // case B, other CPU
	logic ans; // answer flip-flop
	logic [3:0] chan_sel;

	assign is_chan = ~rdt[15] & zgpn_;
	assign is_cpu = rdt[15];
	assign chan_sel = rdt[11:14]; // channel number, rdt[11] is msb
	assign fire = rin && (dly_cnt == dly_w'(dok_dly_ticks - 1));
	assign win = (win_cnt != '0);

	// delay counter, restarts whenever rin falls
	always_ff @(posedge __clk) begin
		if (!rst_n || !rin) begin
			dly_cnt <= '0;
		end else if (dly_cnt != dly_w'(dok_dly_ticks)) begin
			dly_cnt <= dly_cnt + 1'b1; // saturates, so the window fires once
		end
	end

	// one-shot window
	always_ff @(posedge __clk) begin
		if (!rst_n || !rin) begin
			win_cnt <= '0;
		end else if (fire) begin
			win_cnt <= win_w'(dok_ticks);
		end else if (win) begin
			win_cnt <= win_cnt - 1'b1;
		end
	end

	// answer latched as the window closes
	always_ff @(posedge __clk) begin
		if (!rst_n || !rin) begin
			ans <= 1'b0;
		end else if (win_cnt == win_w'(1)) begin
			ans <= is_chan | is_cpu; // a channel request with zgpn_ low gets none
		end
	end

	assign dok = rin & ans; // held until rin drops

	// other CPU, rdt[0] picks the priority
	assign cpu_hi = win & is_cpu & ~rdt[0];
	assign cpu_lo = win & is_cpu & rdt[0];

	// 4-to-16 decoder, enabled by the window
	always_comb begin
		for (int c = 0; c < chan_count; c++)
			chan_req[c] = win & is_chan & (chan_sel == 4'(c));
	end

endmodule

// File: intr/intr_ctl.sv
module intr_ctl(
	input logic __clk,
	input logic rst_n,
	input logic strob1,
	input logic clm,
	// CPU states
	input logic k1,
	input logic i1,
	input logic i2,
	input logic i4,
	// CPU control
	input logic w_rm,
	input logic ck_rz_w,
	input logic zerrz,
	input logic przerw,
	input logic zer,
	input logic wx,
	input logic sin,
	input logic ir14,
	input logic ir15,
	input logic zw,
	// async sources
	input logic pout,
	input logic b_parz,
	input logic b_p0,
	input logic rpa,
	input logic zegar,
	input logic xi,
	input logic fi0,
	input logic fi1,
	input logic fi2,
	input logic fi3,
	input logic oprq,
	// from the bus side
	input logic cpu_hi,
	input logic cpu_lo,
	input logic [0:intr_pkg::chan_count-1] chan_req,
	input logic [0:intr_pkg::word_w-1] w,
	output logic irq,
	output logic przerw_z,
	output logic [0:intr_pkg::num_mask-1] rs,
	output logic [0:intr_pkg::word_w-1] bus_rz,
	output logic [0:intr_pkg::word_w-1] dad
);

	import intr_pkg::*;

	localparam int vec_w = $clog2(num_irq);

	logic soft_any; // software interrupt instruction
	logic soft_hi;
	logic soft_lo;
	logic ck_rzw; // software write of the request bits
	logic rst_rzw; // non-channel clear
	logic rst_rzz; // channel clear
	logic ez_rpz; // entry strobe
	logic enter_d; // one cycle after entry
	logic nk_ad; // channel number readout
	logic pzwi4; // vector readout
	logic chan_svc; // a channel slice is in service
	logic [0:num_irq-1] src, wset, rzclk, rzrst, imask;
	logic [0:num_irq-1] rz, sz, rp, prio_in, prio_out;
	logic [0:num_mask-1] zi;
	logic [vec_w-1:0] vec; // serviced slice number
	logic [vec_w-1:0] chan_vec;

	assign soft_any = wx & sin & strob1;
	assign soft_hi = soft_any & ir14;
	assign soft_lo = soft_any & ir15;
	assign ck_rzw = strob1 & ck_rz_w;
	assign rst_rzw = clm | zerrz;
	assign rst_rzz = clm | k1;
	assign ez_rpz = strob1 & i1 & przerw;

	// source per slice
	always_comb begin
		src = '0; // slice 11 stays idle
		src[irq_nmi] = pout;
		src[irq_parity] = b_parz;
		src[irq_nomem] = b_p0;
		src[irq_cpu_hi] = cpu_hi;
		src[irq_ifpwr] = rpa;
		src[irq_timer] = zegar;
		src[irq_illegal] = xi;
		src[irq_fi0] = fi0;
		src[irq_fi1] = fi1;
		src[irq_fi2] = fi2;
		src[irq_fi3] = fi3;
		for (int c = 0; c < chan_count; c++)
			src[irq_chan0 + c] = chan_req[c];
		src[irq_oprq] = oprq;
		src[irq_cpu_lo] = cpu_lo;
		src[irq_soft_hi] = soft_hi;
		src[irq_soft_lo] = soft_lo;
	end

	// software set values, channels cannot be written
	always_comb begin
		wset = '0;
		wset[0:irq_chan0-1] = w[0:irq_chan0-1];
		wset[irq_oprq:num_irq-1] = w[irq_chan0:word_w-1];
	end

	// per-slice load enable and clear
	always_comb begin
		for (int s = 0; s < num_irq; s++) begin
			if (s >= irq_chan0 && s < irq_chan0 + chan_count) begin
				rzclk[s] = 1'b0; // window pulses only
				rzrst[s] = rst_rzz;
			end else begin
				rzclk[s] = ck_rzw;
				rzrst[s] = rst_rzw;
			end
		end
		// soft interrupt with neither ir bit clears both soft slices
		rzrst[irq_soft_hi] = rst_rzw | (soft_any & ~ir14 & ~ir15);
		rzrst[irq_soft_lo] = rst_rzw | (soft_any & ~ir14 & ~ir15);
	end

	// rs expanded over the groups
	always_comb begin
		imask = '0;
		imask[irq_nmi] = 1'b1; // never masked
		for (int s = 1; s < num_irq; s++) begin
			for (int g = num_mask - 1; g >= 0; g--) begin
				if (s <= mask_group_last[g])
					imask[s] = rs[g]; // lowest fitting group wins
			end
		end
	end

	assign prio_in = {zer, prio_out[0:num_irq-2]};

	always_comb begin
		for (int g = 0; g < num_mask; g++)
			zi[g] = prio_out[mask_group_last[g]];
	end

	always_ff @(posedge __clk) begin
		if (!rst_n)
			enter_d <= 1'b0;
		else
			enter_d <= ez_rpz;
	end

	mask_reg u_mask(
		.__clk(__clk),
		.rst_n(rst_n),
		.clr(clm),
		.load(strob1 & w_rm),
		.enter(enter_d),
		.w(w[0:num_mask-1]),
		.zi(zi),
		.rs(rs)
	);

	for (genvar s = 0; s < num_irq; s++) begin : g_slice
		req_slice u_slice(
			.__clk(__clk),
			.rst_n(rst_n),
			.imask(imask[s]),
			.irq_in(src[s]),
			.w_set(wset[s]),
			.rz_clk(rzclk[s]),
			.rz_rst(rzrst[s]),
			.rp_clk(ez_rpz),
			.prio_in(prio_in[s]),
			.rz(rz[s]),
			.sz(sz[s]),
			.rp(rp[s]),
			.prio_out(prio_out[s])
		);
	end

	assign irq = |sz;
	assign przerw_z = zi[8] & ~zi[4];
	assign bus_rz = {rz[0:irq_chan0-1], rz[irq_oprq:num_irq-1]}; // no channel bits

	// binary number of the serviced slice, at most one rp set
	always_comb begin
		vec = '0;
		for (int s = 0; s < num_irq; s++)
			if (rp[s])
				vec = vec | vec_w'(s);
	end

	assign chan_vec = vec - vec_w'(irq_chan0);
	assign chan_svc = |rp[irq_chan0:irq_chan0+chan_count-1];
	assign nk_ad = i2 & zw;
	assign pzwi4 = przerw & zw & i4;

	// address bus drive during acknowledge
	always_comb begin
		dad = '0;
		if (pzwi4)
			dad[11:15] = vec; // vector number
		if (nk_ad) begin
			dad[4] = 1'b1;
			if (chan_svc)
				dad[11:14] = dad[11:14] | chan_vec[3:0]; // channel number
		end
	end

endmodule

// File: intr/intr_sys.sv
module intr_sys #(
	parameter int dok_dly_ticks = 3, // rin settle time
	parameter int dok_ticks = 4 // acceptance window
) (
	input logic __clk,
	input logic rst_n,
	input logic strob1,
	input logic k1,
	input logic i1,
	input logic i2,
	input logic i4,
	input logic w_rm,
	input logic ck_rz_w,
	input logic zerrz,
	input logic przerw,
	input logic zer,
	input logic wx,
	input logic sin,
	input logic ir14,
	input logic ir15,
	input logic zw,
	input logic zgpn_,
	input logic clm,
	input logic pout,
	input logic b_parz,
	input logic b_p0,
	input logic rpa,
	input logic zegar,
	input logic xi,
	input logic fi0,
	input logic fi1,
	input logic fi2,
	input logic fi3,
	input logic oprq,
	input logic [0:intr_pkg::word_w-1] w,
	input logic rin,
	input logic [0:intr_pkg::word_w-1] rdt,
	output logic irq,
	output logic przerw_z,
	output logic [0:intr_pkg::num_mask-1] rs,
	output logic [0:intr_pkg::word_w-1] bus_rz,
	output logic dok,
	output logic [0:intr_pkg::word_w-1] dad
);

	import intr_pkg::*;

	logic cpu_hi, cpu_lo;
	logic [0:chan_count-1] chan_req; // window level per channel

	intr_ctl u_ctl(
		.__clk(__clk), .rst_n(rst_n), .strob1(strob1), .clm(clm),
		.k1(k1), .i1(i1), .i2(i2), .i4(i4),
		.w_rm(w_rm), .ck_rz_w(ck_rz_w), .zerrz(zerrz), .przerw(przerw),
		.zer(zer), .wx(wx), .sin(sin), .ir14(ir14), .ir15(ir15), .zw(zw),
		.pout(pout), .b_parz(b_parz), .b_p0(b_p0), .rpa(rpa),
		.zegar(zegar), .xi(xi), .fi0(fi0), .fi1(fi1), .fi2(fi2), .fi3(fi3),
		.oprq(oprq), .cpu_hi(cpu_hi), .cpu_lo(cpu_lo), .chan_req(chan_req),
		.w(w), .irq(irq), .przerw_z(przerw_z), .rs(rs), .bus_rz(bus_rz),
		.dad(dad)
	);

	chan_ack #(
		.dok_dly_ticks(dok_dly_ticks),
		.dok_ticks(dok_ticks)
	) u_ack(
		.__clk(__clk),
		.rst_n(rst_n),
		.rin(rin),
		.rdt(rdt),
		.zgpn_(zgpn_),
		.dok(dok),
		.cpu_hi(cpu_hi),
		.cpu_lo(cpu_lo),
		.chan_req(chan_req)
	);

endmodule

// File: tests/tb_intr_tasks.svh
// all outputs idle right after reset
task automatic check_reset;
	expect_eq("reset irq", 32'(irq), 32'(1'b0));
	expect_eq("reset dok", 32'(dok), 32'(1'b0));
	expect_eq("reset rs", 32'(rs), 32'(10'd0));
	expect_eq("reset bus_rz", 32'(bus_rz), 32'(16'd0));
	expect_eq("reset dad", 32'(dad), 32'(16'd0));
endtask

// fi0 sits under mask bit 4, pout under none
task automatic check_masking;
	logic [0:9] m;
	m = 10'($urandom);
	for (int r = 0; r < 2; r++) begin
		if (r == 1)
			m[4] = ~m[4]; // other polarity of the fi0 gate
		clear_requests();
		load_mask(m);
		@(negedge clk);
		fi0 = 1'b1;
		@(negedge clk);
		fi0 = 1'b0;
		expect_eq("masking fi0", 32'(m[group_of(7)]), 32'(irq));
		clear_requests();
		@(negedge clk);
		pout = 1'b1;
		@(negedge clk);
		pout = 1'b0;
		expect_eq("masking pout", 32'(1'b1), 32'(irq));
	end
	clear_requests();
endtask

task automatic soft_set_clear;
	logic [0:15] v;
	logic [0:15] exp;
	v = 16'($urandom);
	clear_requests();
	write_requests(v);
	expect_eq("soft write", 32'(v), 32'(bus_rz));
	@(negedge clk);
	wx = 1'b1;
	sin = 1'b1;
	strob1 = 1'b1;
	ir14 = 1'b1; // slice 30, shown at bus_rz[14]
	@(negedge clk);
	{wx, sin, strob1, ir14} = '0;
	exp = v;
	exp[14] = 1'b1;
	expect_eq("soft ir14", 32'(exp), 32'(bus_rz));
	@(negedge clk);
	zerrz = 1'b1;
	@(negedge clk);
	zerrz = 1'b0;
	expect_eq("soft clear", 32'(16'd0), 32'(bus_rz));
endtask

// one entry cycle, returns after the edge that takes the request
task automatic enter_interrupt;
	@(negedge clk);
	strob1 = 1'b1;
	i1 = 1'b1;
	przerw = 1'b1;
	@(negedge clk);
	{strob1, i1, przerw} = '0;
	@(negedge clk); // request and mask updated
endtask

task automatic read_vector(output logic [0:15] v);
	przerw = 1'b1;
	zw = 1'b1;
	i4 = 1'b1;
	#5 v = dad; // combinational, settled
	@(negedge clk);
	{przerw, zw, i4} = '0;
endtask

task automatic entry_vector;
	logic [0:9] m;
	logic [0:15] v;
	logic [0:15] vec;
	logic [0:15] exp_rz;
	logic [0:9] exp_rs;
	int win;
	int g;
	for (int r = 0; r < 4; r++) begin
		m = 10'($urandom);
		m[9] = 1'b1; // slice 31 always pending and open
		v = 16'($urandom);
		v[15] = 1'b1;
		clear_requests();
		load_mask(m);
		write_requests(v);
		win = -1;
		for (int b = 0; b < 16; b++) begin
			g = group_of(slice_of(b));
			if (win < 0 && v[b] && (g < 0 || m[g]))
				win = slice_of(b); // lowest pending unmasked
		end
		// chain passes slice 27 yet stops by slice 11
		expect_eq("entry przerw_z", 32'((win > 27) && !(win > 11)), 32'(przerw_z));
		enter_interrupt();
		read_vector(vec);
		expect_eq("entry vector", 32'(win), 32'(vec));
		exp_rz = v;
		exp_rz[(win < 12) ? win : win - 16] = 1'b0;
		expect_eq("entry request", 32'(exp_rz), 32'(bus_rz));
		for (int k = 0; k < 10; k++)
			exp_rs[k] = m[k] & (k < group_of(win)); // served group and later close
		expect_eq("entry mask", 32'(exp_rs), 32'(rs));
	end
endtask

// counts edges until dok, capped
task automatic wait_dok(output int n);
	n = 0;
	while (!dok && n < dok_wait_max) begin
		@(posedge clk);
		n++;
		@(negedge clk);
	end
	assert (dok) else begin
		errors++;
		$display("dok did not rise within %0d cycles of rin", n);
	end
endtask

task automatic channel_accept;
	logic [0:9] m;
	logic [3:0] ch;
	logic [0:15] vec;
	int n;
	for (int r = 0; r < 3; r++) begin
		m = 10'($urandom);
		ch = 4'($urandom);
		clear_requests();
		load_mask(m);
		@(negedge clk);
		rdt = '0;
		rdt[11:14] = ch; // rdt[11] is the msb
		rin = 1'b1;
		wait_dok(n);
		expect_eq("chan dok delay", 32'(dok_dly_ticks + dok_ticks), 32'(n));
		expect_eq("chan irq", 32'(m[group_of(12 + int'(ch))]), 32'(irq));
		repeat (3) begin
			@(negedge clk); // requester keeps rin up
			expect_eq("chan dok hold", 32'(1'b1), 32'(dok));
		end
		rin = 1'b0;
		#5 expect_eq("chan dok drop", 32'(1'b0), 32'(dok));
	end
	// other CPU, rdt[0] low is high priority
	for (int p = 0; p < 2; p++) begin
		clear_requests();
		load_mask('1);
		@(negedge clk);
		rdt = '0;
		rdt[15] = 1'b1;
		rdt[0] = (p == 1);
		rin = 1'b1;
		wait_dok(n);
		expect_eq("cpu dok delay", 32'(dok_dly_ticks + dok_ticks), 32'(n));
		@(negedge clk);
		rin = 1'b0;
		enter_interrupt();
		read_vector(vec);
		expect_eq("cpu vector", 32'((p == 1) ? 29 : 3), 32'(vec));
	end
	clear_requests();
endtask

// File: tests/tb_intr.sv
module tb_intr;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int dok_dly_ticks = 3;
	localparam int dok_ticks = 4;
	localparam int dok_wait_max = 4 * (dok_dly_ticks + dok_ticks);
	localparam int timeout_cycles = 2000; // the full sequence needs about 200
	localparam logic [31:0] rand_seed = 32'h8f9e_0d1b;

	logic clk;
	logic rst_n;
	logic strob1, k1, i1, i2, i4;
	logic w_rm, ck_rz_w, zerrz, przerw, zer, wx, sin, ir14, ir15, zw, zgpn_, clm;
	logic pout, b_parz, b_p0, rpa, zegar, xi, fi0, fi1, fi2, fi3, oprq;
	logic rin;
	logic [0:15] w;
	logic [0:15] rdt;
	logic irq, przerw_z, dok;
	logic [0:9] rs;
	logic [0:15] bus_rz;
	logic [0:15] dad;

	int errors;
	int checks;
	int cycles = 0; // run length for the timeout

	intr_sys #(
		.dok_dly_ticks(dok_dly_ticks),
		.dok_ticks(dok_ticks)
	) uut(
		.__clk(clk), .rst_n(rst_n), .strob1(strob1), .k1(k1), .i1(i1), .i2(i2), .i4(i4),
		.w_rm(w_rm), .ck_rz_w(ck_rz_w), .zerrz(zerrz), .przerw(przerw), .zer(zer),
		.wx(wx), .sin(sin), .ir14(ir14), .ir15(ir15), .zw(zw), .zgpn_(zgpn_), .clm(clm),
		.pout(pout), .b_parz(b_parz), .b_p0(b_p0), .rpa(rpa), .zegar(zegar), .xi(xi),
		.fi0(fi0), .fi1(fi1), .fi2(fi2), .fi3(fi3), .oprq(oprq), .w(w),
		.rin(rin), .rdt(rdt), .irq(irq), .przerw_z(przerw_z), .rs(rs),
		.bus_rz(bus_rz), .dok(dok), .dad(dad)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk; // 40 ns period

	// stops a hung run
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("timeout, the run did not finish within %0d cycles", timeout_cycles);
			$display("Test failed");
			$finish;
		end
	end

	// mask bit over a slice, -1 for the unmasked slice 0
	function automatic int group_of(input int s);
		if (s <= 4)
			return s - 1; // one slice per bit
		if (s <= 11)
			return 4;
		if (s <= 13)
			return 5;
		if (s <= 15)
			return 6;
		if (s <= 21)
			return 7;
		if (s <= 27)
			return 8;
		return 9;
	endfunction

	// slice behind a bus_rz bit, channels are not shown
	function automatic int slice_of(input int b);
		return (b < 12) ? b : b + 16;
	endfunction

	task automatic expect_eq(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		checks++;
		assert (exp === act) else begin
			errors++;
			$display("error %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	task automatic load_mask(input logic [0:9] m);
		@(negedge clk);
		w = '0;
		w[0:9] = m;
		strob1 = 1'b1;
		w_rm = 1'b1;
		@(negedge clk);
		strob1 = 1'b0;
		w_rm = 1'b0;
	endtask

	task automatic write_requests(input logic [0:15] v);
		@(negedge clk);
		w = v;
		strob1 = 1'b1;
		ck_rz_w = 1'b1;
		@(negedge clk);
		strob1 = 1'b0;
		ck_rz_w = 1'b0;
	endtask

	task automatic clear_requests;
		@(negedge clk);
		zerrz = 1'b1; // non-channel bits
		k1 = 1'b1; // channel bits
		@(negedge clk);
		zerrz = 1'b0;
		k1 = 1'b0;
	endtask

	`include "tb_intr_tasks.svh"

	initial begin
		void'($urandom(rand_seed));
		errors = 0;
		checks = 0;
		rst_n = 1'b0;
		{strob1, k1, i1, i2, i4} = '0;
		{w_rm, ck_rz_w, zerrz, przerw, wx, sin, ir14, ir15, zw, clm} = '0;
		{pout, b_parz, b_p0, rpa, zegar, xi, fi0, fi1, fi2, fi3, oprq} = '0;
		zer = 1'b1; // feeds the priority chain
		zgpn_ = 1'b1; // channel interrupts accepted
		rin = 1'b0;
		w = '0;
		rdt = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		check_reset();
		check_masking();
		soft_set_clear();
		entry_vector();
		channel_accept();

		@(negedge clk);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: intr.f
+incdir+tests
common/intr_pkg.sv
logic/mask_reg.sv
logic/req_slice.sv
logic/chan_ack.sv
intr/intr_ctl.sv
intr/intr_sys.sv
tests/tb_intr.sv

// File: Makefile
# Verilator build and run of the interrupt subsystem testbench

VERILATOR ?= verilator
TOP ?= tb_intr
FLIST ?= intr.f
BUILD ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= Test completed successfully
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "simulation FAILED, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)
